// File: rtl/deque_pkg.sv
`default_nettype none

package deque_pkg;

    // One stored byte
    typedef logic [7:0] byte_t;

    // Bit 1 separates pops from pushes
    typedef enum logic [1:0] {
        OP_PUSH_HEAD = 2'b00,
        OP_PUSH_TAIL = 2'b01,
        OP_POP_HEAD  = 2'b10,
        OP_POP_TAIL  = 2'b11
    } deque_op_t;

    typedef enum logic {
        ST_OK     = 1'b0,
        ST_REJECT = 1'b1
    } deque_status_t;

    // Data only used by pushes
    typedef struct packed {
        deque_op_t op;
        byte_t     data;
    } deque_cmd_t;

    // Value only meaningful for a successful pop
    typedef struct packed {
        deque_status_t status;
        byte_t         value;
    } deque_rsp_t;

endpackage

`default_nettype wire

// File: rtl/deque_storage.sv
`timescale 1ns/1ps
`default_nettype none

module deque_storage import deque_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire            clock,
    input  wire            rst_n,
    input  wire            store_strobe,
    input  wire deque_op_t store_op,
    input  wire byte_t     store_data,
    output byte_t          read_value
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    typedef logic [DEPTH_LOG2-1:0] ptr_t;

    byte_t mem [DEPTH];

    // Head is the first element, tail is one past the last
    ptr_t head;
    ptr_t tail;
    ptr_t head_dec;
    ptr_t tail_dec;

    assign head_dec = head - 1'b1;
    assign tail_dec = tail - 1'b1;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else if (store_strobe) begin
            case (store_op)
                OP_PUSH_HEAD: head <= head_dec;
                OP_PUSH_TAIL: tail <= tail + 1'b1;
                OP_POP_HEAD:  head <= head + 1'b1;
                OP_POP_TAIL:  tail <= tail_dec;
                default:      head <= head;
            endcase
        end
    end

    // Memory and read register, addressed with the old pointers
    always_ff @(posedge clock) begin
        if (store_strobe) begin
            case (store_op)
                OP_PUSH_HEAD: mem[head_dec] <= store_data;
                OP_PUSH_TAIL: mem[tail] <= store_data;
                OP_POP_HEAD:  read_value <= mem[head];
                OP_POP_TAIL:  read_value <= mem[tail_dec];
                default:      read_value <= read_value;
            endcase
        end
    end

    a_op_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        store_strobe |-> !$isunknown(store_op)
    ) else $error("store_op unknown during strobe");

endmodule

`default_nettype wire

// File: rtl/deque_occupancy.sv
`timescale 1ns/1ps
`default_nettype none

module deque_occupancy #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire                    count_inc,
    input  wire                    count_dec,
    output logic [DEPTH_LOG2:0]    count,
    output logic                   full,
    output logic                   empty
);

    typedef logic [DEPTH_LOG2:0] count_t;

    localparam count_t FULL_COUNT = count_t'(1) << DEPTH_LOG2;

    count_t count_next;

    always_comb begin
        count_next = count;
        if (count_inc) begin
            count_next = count + 1'b1;
        end else if (count_dec) begin
            count_next = count - 1'b1;
        end
    end

    // Flags registered with the count they describe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count <= '0;
            full  <= 1'b0;
            empty <= 1'b1;
        end else begin
            count <= count_next;
            full  <= (count_next == FULL_COUNT);
            empty <= (count_next == '0);
        end
    end

    a_inc_dec_excl: assert property (
        @(posedge clock) disable iff (!rst_n) !(count_inc && count_dec)
    ) else $error("increment and decrement together");

    a_no_overflow: assert property (
        @(posedge clock) disable iff (!rst_n) count_inc |-> !full
    ) else $error("increment while full");

    a_no_underflow: assert property (
        @(posedge clock) disable iff (!rst_n) count_dec |-> !empty
    ) else $error("decrement while empty");

endmodule

`default_nettype wire

// File: rtl/deque_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module deque_sequencer import deque_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire             ready,
    input  wire             req,
    input  wire deque_cmd_t cmd,
    input  wire             full,
    input  wire             empty,
    input  wire byte_t      read_value,
    output logic            busy,
    output logic            ack,
    output deque_rsp_t      rsp,
    output logic            store_strobe,
    output deque_op_t       store_op,
    output byte_t           store_data,
    output logic            count_inc,
    output logic            count_dec
);

    typedef enum logic [1:0] {
        IDLE,
        EXECUTE,
        RESPOND
    } seq_state_t;

    seq_state_t state;
    deque_cmd_t cmd_q;
    logic       legal;
    logic       accept;
    logic       in_push;
    logic       in_legal;
    logic       q_push;

    assign accept   = ready && (state == IDLE) && req;
    assign in_push  = (cmd.op == OP_PUSH_HEAD) || (cmd.op == OP_PUSH_TAIL);
    assign in_legal = in_push ? !full : !empty;
    assign q_push   = (cmd_q.op == OP_PUSH_HEAD) || (cmd_q.op == OP_PUSH_TAIL);

    // Everything holds while ready is low
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
            legal <= 1'b0;
        end else if (ready) begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= EXECUTE;
                        legal <= in_legal;
                    end
                end
                EXECUTE: state <= RESPOND;
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    // Response lands one edge after RESPOND
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= (state == RESPOND) && ready;
        end
    end

    always_ff @(posedge clock) begin
        if ((state == RESPOND) && ready) begin
            rsp.status <= legal ? ST_OK : ST_REJECT;
            rsp.value  <= read_value;
        end
    end

    assign busy         = (state != IDLE);
    assign store_strobe = (state == EXECUTE) && ready && legal;
    assign store_op     = cmd_q.op;
    assign store_data   = cmd_q.data;
    assign count_inc    = store_strobe && q_push;
    assign count_dec    = store_strobe && !q_push;

    a_ack_single: assert property (
        @(posedge clock) disable iff (!rst_n) ack |=> !ack
    ) else $error("ack held for two cycles");

    a_strobe_execute: assert property (
        @(posedge clock) disable iff (!rst_n) store_strobe |-> (state == EXECUTE)
    ) else $error("storage strobe outside EXECUTE");

endmodule

`default_nettype wire

// File: rtl/deque_top.sv
`timescale 1ns/1ps
`default_nettype none

module deque_top import deque_pkg::*; #(
    parameter int DEPTH_LOG2 = 8
) (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 ready,
    input  wire                 req,
    input  wire deque_cmd_t     cmd,
    output logic                busy,
    output logic                ack,
    output deque_rsp_t          rsp,
    output logic [DEPTH_LOG2:0] count
);

    logic      store_strobe;
    deque_op_t store_op;
    byte_t     store_data;
    byte_t     read_value;
    logic      count_inc;
    logic      count_dec;
    logic      full;
    logic      empty;

    deque_sequencer sequencer_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .ready        (ready),
        .req          (req),
        .cmd          (cmd),
        .full         (full),
        .empty        (empty),
        .read_value   (read_value),
        .busy         (busy),
        .ack          (ack),
        .rsp          (rsp),
        .store_strobe (store_strobe),
        .store_op     (store_op),
        .store_data   (store_data),
        .count_inc    (count_inc),
        .count_dec    (count_dec)
    );

    deque_storage #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) storage_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .store_strobe (store_strobe),
        .store_op     (store_op),
        .store_data   (store_data),
        .read_value   (read_value)
    );

    deque_occupancy #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) occupancy_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .count_inc (count_inc),
        .count_dec (count_dec),
        .count     (count),
        .full      (full),
        .empty     (empty)
    );

endmodule

`default_nettype wire

// File: verif/deque_tb.sv
`timescale 1ns/1ps
`default_nettype none

module deque_tb import deque_pkg::*; ;

    localparam int DEPTH_LOG2   = 8;
    localparam int DEPTH        = 1 << DEPTH_LOG2;
    localparam int CLOCK_PERIOD = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int ACK_LIMIT    = 20;
    localparam int NUM_TESTS    = 21;
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS + 1100) * 8 * CLOCK_PERIOD;

    typedef logic [DEPTH_LOG2:0] count_t;

    typedef struct packed {
        logic [8*16-1:0] name;
        deque_op_t       op;
        byte_t           data;
        logic [3:0]      stall;
        deque_status_t   status;
        byte_t           value;
        count_t          count;
    } table_entry_t;

    // Expected results worked out by hand from the deque rules
    localparam table_entry_t TESTS [NUM_TESTS] = '{
        '{"pop head empty",  OP_POP_HEAD,  8'h00, 4'd0, ST_REJECT, 8'h00, 9'd0},
        '{"pop tail empty",  OP_POP_TAIL,  8'h00, 4'd0, ST_REJECT, 8'h00, 9'd0},
        '{"fifo push 1",     OP_PUSH_TAIL, 8'h11, 4'd0, ST_OK,     8'h00, 9'd1},
        '{"fifo push 2",     OP_PUSH_TAIL, 8'h22, 4'd0, ST_OK,     8'h00, 9'd2},
        '{"fifo push 3",     OP_PUSH_TAIL, 8'h33, 4'd0, ST_OK,     8'h00, 9'd3},
        '{"fifo pop 1",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'h11, 9'd2},
        '{"fifo pop 2",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'h22, 9'd1},
        '{"fifo pop 3",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'h33, 9'd0},
        '{"lifo push 1",     OP_PUSH_HEAD, 8'ha1, 4'd0, ST_OK,     8'h00, 9'd1},
        '{"lifo push 2",     OP_PUSH_HEAD, 8'hb2, 4'd0, ST_OK,     8'h00, 9'd2},
        '{"lifo push 3",     OP_PUSH_HEAD, 8'hc3, 4'd0, ST_OK,     8'h00, 9'd3},
        '{"lifo pop 1",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'hc3, 9'd2},
        '{"lifo pop 2",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'hb2, 9'd1},
        '{"lifo pop 3",      OP_POP_HEAD,  8'h00, 4'd0, ST_OK,     8'ha1, 9'd0},
        '{"stall push tail", OP_PUSH_TAIL, 8'h5a, 4'd3, ST_OK,     8'h00, 9'd1},
        '{"stall push head", OP_PUSH_HEAD, 8'h6b, 4'd1, ST_OK,     8'h00, 9'd2},
        '{"stall pop tail",  OP_POP_TAIL,  8'h00, 4'd2, ST_OK,     8'h5a, 9'd1},
        '{"mixed push tail", OP_PUSH_TAIL, 8'h7c, 4'd0, ST_OK,     8'h00, 9'd2},
        '{"mixed pop tail",  OP_POP_TAIL,  8'h00, 4'd0, ST_OK,     8'h7c, 9'd1},
        '{"stall pop head",  OP_POP_HEAD,  8'h00, 4'd4, ST_OK,     8'h6b, 9'd0},
        '{"final pop tail",  OP_POP_TAIL,  8'h00, 4'd0, ST_REJECT, 8'h00, 9'd0}
    };

    logic       clock;
    logic       rst_n;
    logic       ready;
    logic       req;
    deque_cmd_t cmd;
    logic       busy;
    logic       ack;
    deque_rsp_t rsp;
    count_t     count;

    int     errors;
    integer seed;
    byte_t  model [$];

    deque_top #(
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) dut_i (
        .clock (clock),
        .rst_n (rst_n),
        .ready (ready),
        .req   (req),
        .cmd   (cmd),
        .busy  (busy),
        .ack   (ack),
        .rsp   (rsp),
        .count (count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_status(input string name, input deque_status_t exp,
                                input deque_status_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: status expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_value(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: value expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: count expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("Error %s: latency expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Issue one command, optionally stall it, then check the response
    task automatic run_command(input string name, input deque_op_t op, input byte_t data,
                               input int stall, input deque_status_t exp_status,
                               input byte_t exp_value, input count_t exp_count);
        int         latency;
        logic       got_ack;
        logic       lost;
        deque_rsp_t rsp_seen;
        count_t     count_seen;
        latency = 0;
        got_ack = 1'b0;
        lost = 1'b0;
        rsp_seen = '0;
        count_seen = '0;
        if (busy) begin
            errors++;
            $display("DUT still busy before %s was issued", name);
        end
        req = 1'b1;
        cmd = '{op: op, data: data};
        @(posedge clock);
        #DRIVE_DELAY;
        req = 1'b0;
        cmd = '0;
        if (!busy) begin
            errors++;
            $display("busy did not rise after %s was sampled", name);
        end
        if (stall > 0) begin
            ready = 1'b0;
        end
        while (!got_ack && !lost && latency < stall + ACK_LIMIT) begin
            @(posedge clock);
            #DRIVE_DELAY;
            latency++;
            if (latency == stall) begin
                ready = 1'b1;
            end
            if (ack) begin
                got_ack = 1'b1;
                rsp_seen = rsp;
                count_seen = count;
            end else if (!busy) begin
                lost = 1'b1;
                errors++;
                $display("busy dropped without an ack during %s", name);
            end
        end
        ready = 1'b1;
        if (!got_ack && !lost) begin
            errors++;
            $display("No ack arrived for %s", name);
        end
        if (got_ack) begin
            if (busy) begin
                errors++;
                $display("busy still high while ack was shown for %s", name);
            end
            check_latency(name, stall + 2, latency);
            check_status(name, exp_status, rsp_seen.status);
            if ((op == OP_POP_HEAD || op == OP_POP_TAIL) && exp_status == ST_OK) begin
                check_value(name, exp_value, rsp_seen.value);
            end
            check_count(name, exp_count, count_seen);
        end
        @(posedge clock);
        #DRIVE_DELAY;
        if (ack) begin
            errors++;
            $display("ack lasted more than one cycle after %s", name);
        end
    endtask

    // Expected result from the queue model, then run the command
    task automatic model_command(input string name, input deque_op_t op, input byte_t data);
        deque_status_t exp_status;
        byte_t         exp_value;
        exp_status = ST_REJECT;
        exp_value = '0;
        case (op)
            OP_PUSH_HEAD: begin
                if (model.size() < DEPTH) begin
                    model.push_front(data);
                    exp_status = ST_OK;
                end
            end
            OP_PUSH_TAIL: begin
                if (model.size() < DEPTH) begin
                    model.push_back(data);
                    exp_status = ST_OK;
                end
            end
            OP_POP_HEAD: begin
                if (model.size() > 0) begin
                    exp_value = model.pop_front();
                    exp_status = ST_OK;
                end
            end
            default: begin
                if (model.size() > 0) begin
                    exp_value = model.pop_back();
                    exp_status = ST_OK;
                end
            end
        endcase
        run_command(name, op, data, 0, exp_status, exp_value, count_t'(model.size()));
    endtask

    // A req while ready is low must leave no trace
    task automatic check_ignored_req();
        int i;
        ready = 1'b0;
        req = 1'b1;
        cmd = '{op: OP_PUSH_TAIL, data: 8'h99};
        for (i = 0; i < 4; i++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            req = 1'b0;
            cmd = '0;
            if (ack || busy) begin
                errors++;
                $display("DUT reacted to a req while ready was low");
            end
        end
        ready = 1'b1;
        for (i = 0; i < 4; i++) begin
            @(posedge clock);
            #DRIVE_DELAY;
            if (ack || busy) begin
                errors++;
                $display("ack or busy seen for a req that should have been ignored");
            end
        end
        // Table leaves the deque empty
        check_count("ignored req", '0, count);
    endtask

    initial begin
        int    i;
        byte_t data;
        errors = 0;
        seed = 32'h438e874a;
        rst_n = 1'b0;
        ready = 1'b1;
        req = 1'b0;
        cmd = '0;
        repeat (3) @(posedge clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        check_count("after reset", '0, count);
        if (ack || busy) begin
            errors++;
            $display("ack or busy high after reset");
        end

        for (i = 0; i < NUM_TESTS; i++) begin
            run_command($sformatf("%0s", TESTS[i].name), TESTS[i].op, TESTS[i].data,
                        int'(TESTS[i].stall), TESTS[i].status, TESTS[i].value,
                        TESTS[i].count);
        end

        check_ignored_req();

        // Head pushes of the fill wrap the head pointer below zero
        for (i = 0; i < DEPTH; i++) begin
            data = byte_t'($random(seed));
            if (i % 2 == 0) begin
                model_command($sformatf("fill tail %0d", i), OP_PUSH_TAIL, data);
            end else begin
                model_command($sformatf("fill head %0d", i), OP_PUSH_HEAD, data);
            end
        end
        model_command("full push tail", OP_PUSH_TAIL, 8'h5c);
        model_command("full push head", OP_PUSH_HEAD, 8'hc5);

        for (i = 0; i < DEPTH; i++) begin
            model_command($sformatf("drain tail %0d", i), OP_POP_TAIL, 8'h00);
        end
        model_command("drained pop tail", OP_POP_TAIL, 8'h00);

        repeat (2) @(posedge clock);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
rtl/deque_pkg.sv
rtl/deque_storage.sv
rtl/deque_occupancy.sv
rtl/deque_sequencer.sv
rtl/deque_top.sv
verif/deque_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module deque_tb -o deque_sim \
    && ./obj_dir/deque_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^Test OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
